/* dv/kl_top_properties.sv */
`timescale 1ns/10ps

module kl_top_properties (
    input logic             clk,
    input logic             rst,
    input logic             ib_req_valid,
    input logic             ib_req_ready,
    input logic             db_req_valid,
    input logic             db_req_ready,
    input kl_pkg::kl_resp_t ib_resp,
    input logic             ib_resp_valid,
    input logic             ib_resp_ready,
    input kl_pkg::kl_resp_t db_resp,
    input logic             db_resp_valid,
    input logic             db_resp_ready,
    input logic             ml_data_oe,
    input logic [2:0]       bridge_state
);

    // Encoding of the bridge state that waits for inbound beats
    localparam logic [2:0] st_wait_resp = 3'd5;

    // A pending response keeps its valid and its payload until it is taken
    a_ib_resp_hold: assert property (@(posedge clk) disable iff (rst)
        ib_resp_valid && !ib_resp_ready |=> ib_resp_valid && $stable(ib_resp))
        else $error("ib response dropped or changed before it was taken");

    a_db_resp_hold: assert property (@(posedge clk) disable iff (rst)
        db_resp_valid && !db_resp_ready |=> db_resp_valid && $stable(db_resp))
        else $error("db response dropped or changed before it was taken");

    // Ready only falls when an item has just entered the skid entry
    a_ib_ready_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(ib_req_ready) |-> $past(ib_req_valid))
        else $error("ib request ready fell without an accepted item");

    a_db_ready_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(db_req_ready) |-> $past(db_req_valid))
        else $error("db request ready fell without an accepted item");

    // No outbound beat follows a cycle spent waiting for the device
    a_no_oe_in_wait: assert property (@(posedge clk) disable iff (rst)
        bridge_state == st_wait_resp |=> !ml_data_oe)
        else $error("outbound beat driven while the bridge waits for a response");

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real period       = 4.0,
    parameter int  reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    // Reset is released just after an edge, away from the sampling point
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* dv/tb_kl_top.sv */
`timescale 1ns/10ps
`include "kl_defines.svh"

module tb_kl_top;

    import kl_pkg::*;

    localparam logic port_ib    = 1'b0;
    localparam logic port_db    = 1'b1;
    localparam int   num_rows   = 11;
    localparam int   wait_limit = 100;
    // A stalled port absorbs two items in each of its decouplers and one in the bridge
    localparam int   fill_depth = 5;
    // Longer than one bridge transaction with the slowest device answer
    localparam int   settle_cycles = 20;

    typedef struct packed {
        logic                  port;
        logic                  wen;
        logic [`KL_ADDR_W-1:0] addr;
        logic [`KL_DATA_W-1:0] wdata;
        logic [`KL_MASK_W-1:0] wmask;
        logic [`KL_SIZE_W-1:0] size;
        logic [`KL_DATA_W-1:0] exp_rdata;
        logic [3:0]            hold;
        logic                  pair;
    } row_t;

    // One transaction as the memory device saw it on the external bus
    typedef struct packed {
        logic [`ML_DATA_W-1:0] addr;
        logic [`ML_DATA_W-1:0] ctrl;
        logic [`ML_DATA_W-1:0] lo;
        logic [`ML_DATA_W-1:0] hi;
    } bus_txn_t;

    logic                  clk;
    logic                  rst;
    kl_req_t               req [2];
    kl_resp_t              resp [2];
    logic [1:0]            req_valid;
    logic [1:0]            req_ready;
    logic [1:0]            resp_valid;
    logic [1:0]            resp_ready;
    logic [`ML_DATA_W-1:0] ml_data_o;
    logic                  ml_data_oe;
    logic [`ML_DATA_W-1:0] ml_data_i;
    logic                  ml_data_iv;
    logic [`KL_DATA_W-1:0] mem [16];
    bus_txn_t              bus_log [$];
    row_t                  rows [num_rows];
    logic                  last_port;
    int                    error_count = 0;
    int                    check_count = 0;
    integer                seed = 32'h851e9c39;

    tb_clock_gen #(.period(4.0), .reset_cycles(3)) u_clock_gen (.clk(clk), .rst(rst));

    // Index 0 of every port array is the instruction side
    kl_top i_dut (
        .clk(clk), .rst(rst),
        .ib_req(req[0]), .ib_req_valid(req_valid[0]), .ib_req_ready(req_ready[0]),
        .ib_resp(resp[0]), .ib_resp_valid(resp_valid[0]), .ib_resp_ready(resp_ready[0]),
        .db_req(req[1]), .db_req_valid(req_valid[1]), .db_req_ready(req_ready[1]),
        .db_resp(resp[1]), .db_resp_valid(resp_valid[1]), .db_resp_ready(resp_ready[1]),
        .ml_data_o(ml_data_o), .ml_data_oe(ml_data_oe),
        .ml_data_i(ml_data_i), .ml_data_iv(ml_data_iv)
    );

    bind kl_top kl_top_properties u_properties (
        .clk(clk), .rst(rst),
        .ib_req_valid(ib_req_valid), .ib_req_ready(ib_req_ready),
        .db_req_valid(db_req_valid), .db_req_ready(db_req_ready),
        .ib_resp(ib_resp), .ib_resp_valid(ib_resp_valid), .ib_resp_ready(ib_resp_ready),
        .db_resp(db_resp), .db_resp_valid(db_resp_valid), .db_resp_ready(db_resp_ready),
        .ml_data_oe(ml_data_oe), .bridge_state(u_bridge.state)
    );

    function automatic string port_name(input logic port);
        return port ? "db" : "ib";
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic get_beat(output logic [`ML_DATA_W-1:0] beat);
        do begin
            @(posedge clk);
            #1;
        end while (!ml_data_oe);
        beat = ml_data_o;
    endtask

    // External memory device that serves one transaction at a time
    initial begin : memory_device
        bus_txn_t              txn;
        logic [`KL_DATA_W-1:0] wdata;
        logic [3:0]            idx;
        int                    idle;
        ml_data_i  = '0;
        ml_data_iv = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 64'h0101_0101_0101_0101 * (i + 1);
        end
        forever begin
            txn = '0;
            get_beat(txn.addr);
            get_beat(txn.ctrl);
            if (txn.ctrl[`KL_MASK_W + `KL_SIZE_W]) begin
                get_beat(txn.lo);
                get_beat(txn.hi);
            end
            bus_log.push_back(txn);
            idx   = txn.addr[6:3];
            wdata = {txn.hi, txn.lo};
            if (txn.ctrl[`KL_MASK_W + `KL_SIZE_W]) begin
                for (int b = 0; b < `KL_MASK_W; b++) begin
                    if (txn.ctrl[b]) mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            idle = $unsigned($random(seed)) % 8;
            repeat (idle) @(posedge clk);
            @(posedge clk);
            #1;
            ml_data_iv = 1'b1;
            ml_data_i  = txn.ctrl[`KL_MASK_W + `KL_SIZE_W] ? '0 : mem[idx][31:0];
            if (!txn.ctrl[`KL_MASK_W + `KL_SIZE_W]) begin
                @(posedge clk);
                #1;
                ml_data_i = mem[idx][63:32];
            end
            @(posedge clk);
            #1;
            ml_data_iv = 1'b0;
            ml_data_i  = '0;
        end
    end

    // Issues one row on its port and checks the single response it gets
    task automatic run_row(input int r, input logic solo);
        row_t     row;
        int       p;
        int       waited;
        string    pn;
        kl_resp_t got;
        row = rows[r];
        p   = row.port;
        pn  = port_name(row.port);
        req[p] = '{addr: row.addr, wen: row.wen, wdata: row.wdata,
                   wmask: row.wmask, size: row.size};
        req_valid[p]  = 1'b1;
        resp_ready[p] = (row.hold == 0);
        waited = 0;
        while (!req_ready[p] && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk);
        #1;
        req_valid[p] = 1'b0;
        waited = 0;
        while (!resp_valid[p] && waited < wait_limit) begin
            if (solo) check_value({port_name(!row.port), "_resp_valid"}, resp_valid[1-p], 0);
            @(posedge clk);
            #1;
            waited++;
        end
        if (!resp_valid[p]) begin
            error_count++;
            $display("Row %0d got no response on the %s port in %0d cycles", r, pn, waited);
            resp_ready[p] = 1'b1;
            return;
        end
        got = resp[p];
        repeat (row.hold) begin
            @(posedge clk);
            #1;
            check_value({pn, "_resp_valid"}, resp_valid[p], 1);
            check_value({pn, "_resp.rdata"}, resp[p].rdata, got.rdata);
            check_value({pn, "_resp.size"}, resp[p].size, got.size);
        end
        resp_ready[p] = 1'b1;
        @(posedge clk);
        #1;
        check_value({pn, "_resp.rdata"}, got.rdata, row.exp_rdata);
        check_value({pn, "_resp.size"}, got.size, row.size);
        check_value({pn, "_resp_valid"}, resp_valid[p], 0);
    endtask

    task automatic check_bus_txn(input int r);
        bus_txn_t txn;
        if (bus_log.size() == 0) begin
            error_count++;
            $display("No external bus transaction was seen for row %0d", r);
            return;
        end
        txn = bus_log.pop_front();
        check_value("ml_data_o address beat", txn.addr, rows[r].addr);
        check_value("ml_data_o control beat", txn.ctrl,
                    {rows[r].wen, rows[r].size, rows[r].wmask});
        if (rows[r].wen) begin
            check_value("ml_data_o data low beat", txn.lo, rows[r].wdata[31:0]);
            check_value("ml_data_o data high beat", txn.hi, rows[r].wdata[63:32]);
        end
    endtask

    // Stalls one port's responses and issues reads until every buffer on its path is full
    task automatic fill_path(input int p);
        logic [`KL_DATA_W-1:0] exp_rdata [$];
        logic [`KL_ADDR_W-1:0] rd_addr;
        bus_txn_t              txn;
        int                    waited;
        string                 pn;
        pn = port_name(p);
        resp_ready[p] = 1'b0;
        for (int k = 0; k < fill_depth; k++) begin
            rd_addr = 32'h10 + 8 * k;
            exp_rdata.push_back(mem[rd_addr[6:3]]);
            req[p] = '{addr: rd_addr, wen: 1'b0, wdata: '0, wmask: '0, size: 3'd3};
            req_valid[p] = 1'b1;
            waited = 0;
            while (!req_ready[p] && waited < wait_limit) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!req_ready[p]) begin
                error_count++;
                $display("The %s port took only %0d requests before it stalled", pn, k);
                req_valid[p]  = 1'b0;
                resp_ready[p] = 1'b1;
                return;
            end
            @(posedge clk);
            #1;
        end
        req_valid[p] = 1'b0;
        // The bridge reaches its stalled response well within this time
        repeat (settle_cycles) @(posedge clk);
        #1;
        check_value({pn, "_req_ready"}, req_ready[p], 0);
        check_value({pn, "_resp_valid"}, resp_valid[p], 1);
        resp_ready[p] = 1'b1;
        for (int k = 0; k < fill_depth; k++) begin
            waited = 0;
            while (!resp_valid[p] && waited < wait_limit) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!resp_valid[p]) begin
                error_count++;
                $display("Read %0d of the filled %s port never completed", k, pn);
                return;
            end
            check_value({pn, "_resp.rdata"}, resp[p].rdata, exp_rdata.pop_front());
            check_value({pn, "_resp.size"}, resp[p].size, 3'd3);
            txn = bus_log.pop_front();
            check_value("ml_data_o address beat", txn.addr, 32'h10 + 8 * k);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : main
        int r;
        int first;
        int second;
        // port, wen, addr, wdata, wmask, size, expected rdata, hold cycles, pair
        rows = '{
            '{port_db, 1'b1, 32'h20, 64'h1122_3344_5566_7788, 8'h0f, 3'd3, 64'h0, 4'd0, 1'b0},
            '{port_db, 1'b0, 32'h20, 64'h0, 8'h00, 3'd3, 64'h0505_0505_5566_7788, 4'd2, 1'b0},
            '{port_ib, 1'b0, 32'h20, 64'h0, 8'h00, 3'd3, 64'h0505_0505_5566_7788, 4'd0, 1'b0},
            '{port_ib, 1'b0, 32'h48, 64'h0, 8'h00, 3'd2, 64'h0a0a_0a0a_0a0a_0a0a, 4'd0, 1'b1},
            '{port_db, 1'b1, 32'h50, 64'hdead_beef_0bad_f00d, 8'hf0, 3'd3, 64'h0, 4'd0, 1'b0},
            '{port_db, 1'b0, 32'h50, 64'h0, 8'h00, 3'd3, 64'hdead_beef_0b0b_0b0b, 4'd0, 1'b0},
            '{port_ib, 1'b0, 32'h08, 64'h0, 8'h00, 3'd1, 64'h0202_0202_0202_0202, 4'd5, 1'b1},
            '{port_db, 1'b1, 32'h78, 64'h0123_4567_89ab_cdef, 8'h3c, 3'd3, 64'h0, 4'd0, 1'b0},
            '{port_ib, 1'b1, 32'h00, 64'hffff_ffff_ffff_ffff, 8'h81, 3'd3, 64'h0, 4'd3, 1'b1},
            '{port_db, 1'b0, 32'h78, 64'h0, 8'h00, 3'd3, 64'h1010_4567_89ab_1010, 4'd4, 1'b0},
            '{port_ib, 1'b0, 32'h00, 64'h0, 8'h00, 3'd3, 64'hff01_0101_0101_01ff, 4'd0, 1'b0}
        };
        req[0]     = '0;
        req[1]     = '0;
        req_valid  = 2'b00;
        resp_ready = 2'b11;
        last_port  = port_ib;
        @(negedge rst);
        @(posedge clk);
        #1;
        check_value("ib_resp_valid", resp_valid[0], 0);
        check_value("db_resp_valid", resp_valid[1], 0);
        check_value("ml_data_oe", ml_data_oe, 0);
        check_value("ib_req_ready", req_ready[0], 1);
        check_value("db_req_ready", req_ready[1], 1);
        r = 0;
        while (r < num_rows) begin
            if (rows[r].pair && r + 1 < num_rows) begin
                fork
                    run_row(r, 1'b0);
                    run_row(r + 1, 1'b0);
                join
                // Round robin serves first the port that was not served last
                first  = (rows[r].port != last_port) ? r : r + 1;
                second = (first == r) ? r + 1 : r;
                check_bus_txn(first);
                check_bus_txn(second);
                last_port = rows[second].port;
                r += 2;
            end else begin
                run_row(r, 1'b1);
                check_bus_txn(r);
                last_port = rows[r].port;
                r++;
            end
        end
        fill_path(port_ib);
        fill_path(port_db);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (num_rows * 100) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the tests finishing",
                 num_rows * 100);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+src
src/kl_pkg.sv
src/kl_decoupler.sv
src/kl_arbiter_2by1.sv
src/kl2ml_bridge.sv
src/kl_top.sv
dv/tb_clock_gen.sv
dv/kl_top_properties.sv
dv/tb_kl_top.sv

/* src/kl2ml_bridge.sv */
`timescale 1ns/10ps
`include "kl_defines.svh"

module kl2ml_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  kl_pkg::kl_bus_req_t   kl_req,
    input  logic                  kl_req_valid,
    output logic                  kl_req_ready,
    output kl_pkg::kl_bus_resp_t  kl_resp,
    output logic                  kl_resp_valid,
    input  logic                  kl_resp_ready,
    output logic [`ML_DATA_W-1:0] ml_data_o,
    output logic                  ml_data_oe,
    input  logic [`ML_DATA_W-1:0] ml_data_i,
    input  logic                  ml_data_iv
);

    import kl_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_ADDR,
        ST_SEND_CTRL,
        ST_SEND_DLO,
        ST_SEND_DHI,
        ST_WAIT_RESP,
        ST_RESPOND
    } state_t;

    state_t                   state;
    kl_req_t                  req;
    logic [`ML_DATA_W-1:0]    ctrl_beat;
    logic [4*`ML_DATA_W-1:0]  shift_q;
    logic                     wen_q;
    logic [`KL_SIZE_W-1:0]    size_q;
    logic [`KL_SRCID_W-1:0]   srcid_q;
    logic [`KL_DATA_W-1:0]    rdata_q;
    logic                     second_beat;
    logic                     req_fire;
    logic                     beat_in;

    assign req = kl_req.req;

    // Control beat layout is wmask in [7:0], size above it, then wen
    assign ctrl_beat = {{(`ML_DATA_W - `KL_SIZE_W - `KL_MASK_W - 1){1'b0}},
                        req.wen, req.size, req.wmask};

    assign kl_req_ready = state == ST_IDLE;
    assign req_fire     = kl_req_valid && kl_req_ready;
    assign beat_in      = (state == ST_WAIT_RESP) && ml_data_iv;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            second_beat <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (kl_req_valid) begin
                        state       <= ST_SEND_ADDR;
                        second_beat <= 1'b0;
                    end
                end
                ST_SEND_ADDR: state <= ST_SEND_CTRL;
                ST_SEND_CTRL: state <= wen_q ? ST_SEND_DLO : ST_WAIT_RESP;
                ST_SEND_DLO:  state <= ST_SEND_DHI;
                ST_SEND_DHI:  state <= ST_WAIT_RESP;
                ST_WAIT_RESP: begin
                    // A write needs only the acknowledge, a read needs both words
                    if (ml_data_iv) begin
                        if (wen_q || second_beat) begin
                            state <= ST_RESPOND;
                        end
                        second_beat <= 1'b1;
                    end
                end
                ST_RESPOND: begin
                    if (kl_resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Beats leave from the bottom of the shift register, lowest word first
    always_ff @(posedge clk) begin
        if (req_fire) begin
            shift_q <= {req.wdata, ctrl_beat, req.addr};
            wen_q   <= req.wen;
            size_q  <= req.size;
            srcid_q <= kl_req.srcid;
            rdata_q <= '0;
        end else if (ml_data_oe) begin
            shift_q <= shift_q >> `ML_DATA_W;
        end
        if (beat_in && !wen_q) begin
            if (second_beat) begin
                rdata_q[`KL_DATA_W-1:`ML_DATA_W] <= ml_data_i;
            end else begin
                rdata_q[`ML_DATA_W-1:0] <= ml_data_i;
            end
        end
    end

    assign ml_data_o  = shift_q[`ML_DATA_W-1:0];
    assign ml_data_oe = (state == ST_SEND_ADDR) || (state == ST_SEND_CTRL) ||
                        (state == ST_SEND_DLO) || (state == ST_SEND_DHI);

    assign kl_resp_valid = state == ST_RESPOND;
    assign kl_resp       = '{resp: '{rdata: rdata_q, size: size_q}, dstid: srcid_q};

endmodule

/* src/kl_arbiter_2by1.sv */
`timescale 1ns/10ps
`include "kl_defines.svh"

module kl_arbiter_2by1 (
    input  logic                 clk,
    input  logic                 rst,
    // Instruction port
    input  kl_pkg::kl_req_t      up0_req,
    input  logic                 up0_req_valid,
    output logic                 up0_req_ready,
    output kl_pkg::kl_resp_t     up0_resp,
    output logic                 up0_resp_valid,
    input  logic                 up0_resp_ready,
    // Data port
    input  kl_pkg::kl_req_t      up1_req,
    input  logic                 up1_req_valid,
    output logic                 up1_req_ready,
    output kl_pkg::kl_resp_t     up1_resp,
    output logic                 up1_resp_valid,
    input  logic                 up1_resp_ready,
    // Merged tagged bus towards the bridge
    output kl_pkg::kl_bus_req_t  dn_req,
    output logic                 dn_req_valid,
    input  logic                 dn_req_ready,
    input  kl_pkg::kl_bus_resp_t dn_resp,
    input  logic                 dn_resp_valid,
    output logic                 dn_resp_ready
);

    import kl_pkg::*;

    logic                   last_q;
    logic                   lock_q;
    logic                   lock_sel_q;
    logic                   sel;
    kl_req_t                sel_req;
    logic [`KL_SRCID_W-1:0] sel_srcid;
    logic                   to_ib;
    logic                   to_db;

    // sel is 0 for the instruction port and 1 for the data port
    always_comb begin
        if (lock_q) begin
            sel = lock_sel_q;
        end else if (up0_req_valid && up1_req_valid) begin
            sel = !last_q;
        end else begin
            sel = up1_req_valid;
        end
    end

    assign sel_req   = sel ? up1_req : up0_req;
    assign sel_srcid = sel ? `KL_SRCID_W'(`KL_SRC_DB) : `KL_SRCID_W'(`KL_SRC_IB);

    assign dn_req        = '{req: sel_req, srcid: sel_srcid};
    assign dn_req_valid  = sel ? up1_req_valid : up0_req_valid;
    assign up0_req_ready = dn_req_ready && !sel;
    assign up1_req_ready = dn_req_ready && sel;

    // Round-robin history and the grant lock while the bridge is busy
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q     <= 1'b1;
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else if (dn_req_valid && dn_req_ready) begin
            last_q <= sel;
            lock_q <= 1'b0;
        end else if (dn_req_valid) begin
            lock_q     <= 1'b1;
            lock_sel_q <= sel;
        end
    end

    // Responses are steered by their destination tag
    assign to_ib = dn_resp.dstid == `KL_SRCID_W'(`KL_SRC_IB);
    assign to_db = dn_resp.dstid == `KL_SRCID_W'(`KL_SRC_DB);

    assign up0_resp       = dn_resp.resp;
    assign up1_resp       = dn_resp.resp;
    assign up0_resp_valid = dn_resp_valid && to_ib;
    assign up1_resp_valid = dn_resp_valid && to_db;
    assign dn_resp_ready  = (to_ib && up0_resp_ready) || (to_db && up1_resp_ready);

endmodule

/* src/kl_decoupler.sv */
`timescale 1ns/10ps

module kl_decoupler #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t up,
    input  logic     up_valid,
    output logic     up_ready,
    output payload_t dn,
    output logic     dn_valid,
    input  logic     dn_ready
);

    // Second entry catches the item that arrives while the output is stalled
    payload_t skid_q;
    logic     skid_valid_q;
    logic     up_fire;
    logic     dn_free;

    // Ready is a pure function of a register, so no path runs through
    assign up_ready = !skid_valid_q;
    assign up_fire  = up_valid && up_ready;
    assign dn_free  = dn_ready || !dn_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dn_valid     <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (dn_free) begin
            if (skid_valid_q) begin
                // Older item waiting in the skid entry goes out first
                dn_valid     <= 1'b1;
                skid_valid_q <= 1'b0;
            end else begin
                dn_valid <= up_fire;
            end
        end else if (up_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dn_free) begin
            if (skid_valid_q) begin
                dn <= skid_q;
            end else if (up_fire) begin
                dn <= up;
            end
        end else if (up_fire) begin
            skid_q <= up;
        end
    end

endmodule

/* src/kl_defines.svh */
`ifndef KL_DEFINES_SVH
`define KL_DEFINES_SVH

// Internal kl bus widths
`define KL_ADDR_W   32
`define KL_DATA_W   64
`define KL_MASK_W   8
`define KL_SIZE_W   3
`define KL_SRCID_W  5

// Width of one beat on the external memory bus
`define ML_DATA_W   32

// Source ids attached by the arbiter
`define KL_SRC_IB   0
`define KL_SRC_DB   1

`endif

/* src/kl_pkg.sv */
`include "kl_defines.svh"

package kl_pkg;

    // One request as issued by a core port
    typedef struct packed {
        logic [`KL_ADDR_W-1:0]  addr;
        logic                   wen;
        logic [`KL_DATA_W-1:0]  wdata;
        logic [`KL_MASK_W-1:0]  wmask;
        logic [`KL_SIZE_W-1:0]  size;
    } kl_req_t;

    // One response back to a core port, rdata is zero for writes
    typedef struct packed {
        logic [`KL_DATA_W-1:0]  rdata;
        logic [`KL_SIZE_W-1:0]  size;
    } kl_resp_t;

    // Request tagged with the port it came from
    typedef struct packed {
        kl_req_t                req;
        logic [`KL_SRCID_W-1:0] srcid;
    } kl_bus_req_t;

    // Response tagged with the port it goes back to
    typedef struct packed {
        kl_resp_t               resp;
        logic [`KL_SRCID_W-1:0] dstid;
    } kl_bus_resp_t;

endpackage

/* src/kl_top.sv */
`timescale 1ns/10ps
`include "kl_defines.svh"

module kl_top (
    input  logic                  clk,
    input  logic                  rst,
    input  kl_pkg::kl_req_t       ib_req,
    input  logic                  ib_req_valid,
    output logic                  ib_req_ready,
    output kl_pkg::kl_resp_t      ib_resp,
    output logic                  ib_resp_valid,
    input  logic                  ib_resp_ready,
    input  kl_pkg::kl_req_t       db_req,
    input  logic                  db_req_valid,
    output logic                  db_req_ready,
    output kl_pkg::kl_resp_t      db_resp,
    output logic                  db_resp_valid,
    input  logic                  db_resp_ready,
    output logic [`ML_DATA_W-1:0] ml_data_o,
    output logic                  ml_data_oe,
    input  logic [`ML_DATA_W-1:0] ml_data_i,
    input  logic                  ml_data_iv
);

    import kl_pkg::*;

    // Links between the decouplers and the arbiter
    kl_req_t      ib_req_buf;
    logic         ib_req_buf_valid;
    logic         ib_req_buf_ready;
    kl_resp_t     ib_resp_buf;
    logic         ib_resp_buf_valid;
    logic         ib_resp_buf_ready;
    kl_req_t      db_req_buf;
    logic         db_req_buf_valid;
    logic         db_req_buf_ready;
    kl_resp_t     db_resp_buf;
    logic         db_resp_buf_valid;
    logic         db_resp_buf_ready;
    // Tagged bus between the arbiter and the bridge
    kl_bus_req_t  bus_req;
    logic         bus_req_valid;
    logic         bus_req_ready;
    kl_bus_resp_t bus_resp;
    logic         bus_resp_valid;
    logic         bus_resp_ready;

    kl_decoupler #(.payload_t(kl_req_t)) u_ib_req (
        .clk(clk), .rst(rst),
        .up(ib_req), .up_valid(ib_req_valid), .up_ready(ib_req_ready),
        .dn(ib_req_buf), .dn_valid(ib_req_buf_valid), .dn_ready(ib_req_buf_ready)
    );

    kl_decoupler #(.payload_t(kl_req_t)) u_db_req (
        .clk(clk), .rst(rst),
        .up(db_req), .up_valid(db_req_valid), .up_ready(db_req_ready),
        .dn(db_req_buf), .dn_valid(db_req_buf_valid), .dn_ready(db_req_buf_ready)
    );

    kl_decoupler #(.payload_t(kl_resp_t)) u_ib_resp (
        .clk(clk), .rst(rst),
        .up(ib_resp_buf), .up_valid(ib_resp_buf_valid), .up_ready(ib_resp_buf_ready),
        .dn(ib_resp), .dn_valid(ib_resp_valid), .dn_ready(ib_resp_ready)
    );

    kl_decoupler #(.payload_t(kl_resp_t)) u_db_resp (
        .clk(clk), .rst(rst),
        .up(db_resp_buf), .up_valid(db_resp_buf_valid), .up_ready(db_resp_buf_ready),
        .dn(db_resp), .dn_valid(db_resp_valid), .dn_ready(db_resp_ready)
    );

    kl_arbiter_2by1 u_arbiter (
        .clk(clk), .rst(rst),
        .up0_req(ib_req_buf), .up0_req_valid(ib_req_buf_valid),
        .up0_req_ready(ib_req_buf_ready),
        .up0_resp(ib_resp_buf), .up0_resp_valid(ib_resp_buf_valid),
        .up0_resp_ready(ib_resp_buf_ready),
        .up1_req(db_req_buf), .up1_req_valid(db_req_buf_valid),
        .up1_req_ready(db_req_buf_ready),
        .up1_resp(db_resp_buf), .up1_resp_valid(db_resp_buf_valid),
        .up1_resp_ready(db_resp_buf_ready),
        .dn_req(bus_req), .dn_req_valid(bus_req_valid), .dn_req_ready(bus_req_ready),
        .dn_resp(bus_resp), .dn_resp_valid(bus_resp_valid), .dn_resp_ready(bus_resp_ready)
    );

    kl2ml_bridge u_bridge (
        .clk(clk), .rst(rst),
        .kl_req(bus_req), .kl_req_valid(bus_req_valid), .kl_req_ready(bus_req_ready),
        .kl_resp(bus_resp), .kl_resp_valid(bus_resp_valid), .kl_resp_ready(bus_resp_ready),
        .ml_data_o(ml_data_o), .ml_data_oe(ml_data_oe),
        .ml_data_i(ml_data_i), .ml_data_iv(ml_data_iv)
    );

endmodule
